// ==== src/fire_pkg.sv ====
/*
 * Datapath definitions for the fire4/fire5 expand 1x1 engine.
 * Sizes, the layer select and the fixed Q2.14 weight and Q4.28 bias tables.
 */
package fire_pkg;

	// Pixel and weight width, Q2.14
	localparam int FIRE_WIDTH         = 16;
	// Product sum and bias width, Q4.28
	localparam int FIRE_ACC_WIDTH     = 32;
	localparam int FIRE_CHIN          = 8;
	localparam int FIRE_CHOUT         = 4;
	localparam int FIRE_CHAN_BITS     = 3;
	localparam int FIRE_PIX_CNT_WIDTH = 16;

	// Layer opcode, picks the weight and bias set
	typedef enum logic [0:0] {
		LAYER_FIRE4 = 1'b0,
		LAYER_FIRE5 = 1'b1
	} layer_e;

	////////////////////////////////////////////////////////////////////////////
	// Weights [layer][output channel][input channel], 1.0 = 16384
	////////////////////////////////////////////////////////////////////////////
	localparam logic signed [FIRE_WIDTH-1:0] FIRE_WEIGHTS [2][FIRE_CHOUT][FIRE_CHIN] = '{
		// Fire4 set
		'{
			'{16'sd4096, 16'sd2048, -16'sd1024, 16'sd8192,
			  16'sd512, -16'sd2048, 16'sd3072, 16'sd1024},
			'{-16'sd4096, 16'sd6144, 16'sd1024, -16'sd512,
			  16'sd2048, 16'sd4096, -16'sd3072, 16'sd256},
			'{16'sd16384, -16'sd8192, 16'sd2048, 16'sd1024,
			  -16'sd1024, 16'sd512, 16'sd4096, -16'sd2048},
			'{16'sd1024, 16'sd1024, 16'sd1024, 16'sd1024,
			  -16'sd6144, 16'sd2048, 16'sd768, 16'sd5120}
		},
		// Fire5 set, leans negative so ReLU clamps some lanes
		'{
			'{-16'sd8192, -16'sd4096, 16'sd2048, -16'sd1024,
			  -16'sd2048, 16'sd512, -16'sd3072, -16'sd4096},
			'{16'sd3072, 16'sd2048, -16'sd6144, 16'sd4096,
			  16'sd1024, -16'sd512, 16'sd2048, 16'sd1536},
			'{-16'sd1024, 16'sd8192, -16'sd2048, -16'sd2048,
			  16'sd4096, -16'sd8192, 16'sd1024, 16'sd2048},
			'{16'sd12288, -16'sd16384, 16'sd4096, 16'sd256,
			  -16'sd768, 16'sd3072, -16'sd1024, 16'sd6144}
		}
	};

	// Biases [layer][output channel], 1.0 = 2**28
	localparam logic signed [FIRE_ACC_WIDTH-1:0] FIRE_BIAS [2][FIRE_CHOUT] = '{
		'{32'sd67108864, -32'sd33554432, 32'sd16777216, 32'sd0},
		'{-32'sd134217728, 32'sd33554432, -32'sd67108864, 32'sd8388608}
	};

endpackage

// ==== src/apb_pkg.sv ====
/*
 * APB register map of the expand engine.
 * Address and data widths, register offsets and status field positions.
 */
package apb_pkg;

	localparam int APB_ADDR_WIDTH = 8;
	localparam int APB_DATA_WIDTH = 32;

	// Byte offsets, anything else answers with a slave error
	typedef enum logic [APB_ADDR_WIDTH-1:0] {
		REG_CTRL   = 8'h00,
		REG_PIX    = 8'h04,
		REG_STATUS = 8'h08,
		REG_OUT0   = 8'h10,
		REG_OUT1   = 8'h14,
		REG_OUT2   = 8'h18,
		REG_OUT3   = 8'h1C
	} reg_addr_e;

	// REG_STATUS fields
	localparam int STATUS_DONE_BIT = 0;
	localparam int STATUS_CNT_LSB  = 16;

endpackage

// ==== src/fire_apb_regs.sv ====
/*
 * APB slave of the expand engine. Turns writes into layer, clear and pixel
 * beats, and holds the four results and the done flag for readback.
 */
`timescale 1ns/100ps

module fire_apb_regs
	import fire_pkg::*;
	import apb_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_gen,
	input  logic [APB_ADDR_WIDTH-1:0]     paddr_i,
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  logic [APB_DATA_WIDTH-1:0]     pwdata_i,
	input  logic [FIRE_PIX_CNT_WIDTH-1:0] pix_count_i,
	input  logic [FIRE_WIDTH-1:0]         ofm_i [FIRE_CHOUT],
	input  logic                          ofm_valid_i,
	output logic [APB_DATA_WIDTH-1:0]     prdata_o,
	output logic                          pready_o,
	output logic                          pslverr_o,
	output layer_e                        layer_o,
	output logic                          pix_valid_o,
	output logic [FIRE_WIDTH-1:0]         pix_data_o,
	output logic                          clear_o
);

	reg_addr_e             addr;
	logic                  access;
	logic                  addr_hit;
	logic                  addr_wr_ok;
	logic                  wr_ctrl;
	logic                  wr_pix;
	logic                  done_q;
	logic [FIRE_WIDTH-1:0] ofm_q [FIRE_CHOUT];

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////
	assign addr   = reg_addr_e'(paddr_i);
	// Transfer completes in the access phase
	assign access = psel_i & penable_i;

	always_comb begin
		addr_hit   = 1'b1;
		addr_wr_ok = 1'b0;
		case (addr)
			REG_CTRL, REG_PIX: addr_wr_ok = 1'b1;
			REG_STATUS, REG_OUT0, REG_OUT1, REG_OUT2, REG_OUT3: addr_wr_ok = 1'b0;
			default: addr_hit = 1'b0;
		endcase
	end

	assign wr_ctrl   = access & pwrite_i & (addr == REG_CTRL);
	assign wr_pix    = access & pwrite_i & (addr == REG_PIX);
	// Unmapped address or write to a read-only register
	assign pslverr_o = access & (~addr_hit | (pwrite_i & ~addr_wr_ok));
	// No wait states, one channel per access is the datapath rate
	assign pready_o  = 1'b1;

	// Control state and beat pulses
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			layer_o     <= LAYER_FIRE4;
			pix_valid_o <= 1'b0;
			clear_o     <= 1'b0;
			done_q      <= 1'b0;
		end else begin
			pix_valid_o <= wr_pix;
			clear_o     <= wr_ctrl;
			if (wr_ctrl)
				layer_o <= layer_e'(pwdata_i[0]);
			// Fresh results win over a new pixel beat
			if (ofm_valid_i)
				done_q <= 1'b1;
			else if (wr_pix)
				done_q <= 1'b0;
		end
	end

	// Channel value, only meaningful with pix_valid_o
	always_ff @(posedge clk) begin
		if (wr_pix)
			pix_data_o <= pwdata_i[FIRE_WIDTH-1:0];
	end

	// Result registers
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			for (int i = 0; i < FIRE_CHOUT; i++)
				ofm_q[i] <= '0;
		end else if (ofm_valid_i) begin
			ofm_q <= ofm_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		prdata_o = '0;
		case (addr)
			REG_CTRL:   prdata_o[0] = layer_o;
			REG_PIX:    prdata_o[FIRE_WIDTH-1:0] = pix_data_o;
			REG_STATUS: begin
				prdata_o[STATUS_CNT_LSB +: FIRE_PIX_CNT_WIDTH] = pix_count_i;
				prdata_o[STATUS_DONE_BIT] = done_q;
			end
			REG_OUT0:   prdata_o[FIRE_WIDTH-1:0] = ofm_q[0];
			REG_OUT1:   prdata_o[FIRE_WIDTH-1:0] = ofm_q[1];
			REG_OUT2:   prdata_o[FIRE_WIDTH-1:0] = ofm_q[2];
			REG_OUT3:   prdata_o[FIRE_WIDTH-1:0] = ofm_q[3];
			default:    prdata_o = '0;
		endcase
	end

endmodule

// ==== src/fire_pixel_seq.sv ====
/*
 * Pixel sequencer. Walks the input channel index over each pixel, flags
 * the last channel and counts finished output pixels.
 */
`timescale 1ns/100ps

module fire_pixel_seq
	import fire_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_gen,
	input  logic                          clear_i,
	input  logic                          pix_valid_i,
	output logic [FIRE_CHAN_BITS-1:0]     chan_o,
	output logic                          last_o,
	output logic [FIRE_PIX_CNT_WIDTH-1:0] pix_count_o
);

	// Idle between pixels, accum while channels are arriving
	typedef enum logic {
		SEQ_IDLE,
		SEQ_ACCUM
	} seq_state_e;

	seq_state_e state_q;

	// Last channel beat of the current pixel
	assign last_o = pix_valid_i & (state_q == SEQ_ACCUM) &&
		(chan_o == FIRE_CHAN_BITS'(FIRE_CHIN - 1));

	////////////////////////////////////////////////////////////////////////////
	// Channel index, state and pixel counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen || clear_i) begin
			// Control write drops any half pixel
			state_q     <= SEQ_IDLE;
			chan_o      <= '0;
			pix_count_o <= '0;
		end else if (pix_valid_i) begin
			if (last_o) begin
				// Wrap and count the finished pixel
				state_q     <= SEQ_IDLE;
				chan_o      <= '0;
				pix_count_o <= pix_count_o + 1'b1;
			end else begin
				state_q <= SEQ_ACCUM;
				chan_o  <= chan_o + 1'b1;
			end
		end
	end

endmodule

// ==== src/fire_mac_array.sv ====
/*
 * Four MAC lanes, one per output channel. Each beat adds pixel times the
 * selected layer's weight; the last beat publishes the lane sums.
 */
`timescale 1ns/100ps

module fire_mac_array
	import fire_pkg::*;
(
	input  logic                             clk,
	input  logic                             rst_gen,
	input  logic                             clear_i,
	input  layer_e                           layer_i,
	input  logic                             pix_valid_i,
	input  logic [FIRE_WIDTH-1:0]            pix_data_i,
	input  logic [FIRE_CHAN_BITS-1:0]        chan_i,
	input  logic                             last_i,
	output logic signed [FIRE_ACC_WIDTH-1:0] sum_o [FIRE_CHOUT],
	output logic                             sum_valid_o
);

	logic signed [FIRE_ACC_WIDTH-1:0] prod [FIRE_CHOUT];
	logic signed [FIRE_ACC_WIDTH-1:0] acc_q [FIRE_CHOUT];

	// Signed Q2.14 x Q2.14 gives Q4.28
	always_comb begin
		for (int l = 0; l < FIRE_CHOUT; l++)
			prod[l] = $signed(pix_data_i) * FIRE_WEIGHTS[layer_i][l][chan_i];
	end

	////////////////////////////////////////////////////////////////////////////
	// Accumulators, 32 bit wrap
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen || clear_i) begin
			for (int l = 0; l < FIRE_CHOUT; l++)
				acc_q[l] <= '0;
			sum_valid_o <= 1'b0;
		end else begin
			sum_valid_o <= pix_valid_i & last_i;
			for (int l = 0; l < FIRE_CHOUT; l++) begin
				if (pix_valid_i)
					// Restart from zero after the last channel
					acc_q[l] <= last_i ? '0 : acc_q[l] + prod[l];
			end
		end
	end

	// Final sum includes the last product
	always_ff @(posedge clk) begin
		if (pix_valid_i && last_i) begin
			for (int l = 0; l < FIRE_CHOUT; l++)
				sum_o[l] <= acc_q[l] + prod[l];
		end
	end

endmodule

// ==== src/fire_requant.sv ====
/*
 * Output stage. Adds the layer bias to each lane sum, applies ReLU and
 * takes bits 28:14 back to a 16-bit Q2.14 result.
 */
`timescale 1ns/100ps

module fire_requant
	import fire_pkg::*;
(
	input  logic                             clk,
	input  logic                             rst_gen,
	input  layer_e                           layer_i,
	input  logic signed [FIRE_ACC_WIDTH-1:0] sum_i [FIRE_CHOUT],
	input  logic                             sum_valid_i,
	output logic [FIRE_WIDTH-1:0]            ofm_o [FIRE_CHOUT],
	output logic                             ofm_valid_o
);

	logic signed [FIRE_ACC_WIDTH-1:0] biased [FIRE_CHOUT];
	logic [FIRE_WIDTH-1:0]            ofm_d [FIRE_CHOUT];

	////////////////////////////////////////////////////////////////////////////
	// Bias, ReLU, requantize
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int l = 0; l < FIRE_CHOUT; l++) begin
			// Wraps like the lane sum
			biased[l] = sum_i[l] + FIRE_BIAS[layer_i][l];
			// Negative clamps to zero
			if (biased[l][FIRE_ACC_WIDTH-1])
				ofm_d[l] = '0;
			else
				ofm_d[l] = {1'b0, biased[l][28:14]};
		end
	end

	// Valid pulse one cycle after the sums
	always_ff @(posedge clk) begin
		if (rst_gen)
			ofm_valid_o <= 1'b0;
		else
			ofm_valid_o <= sum_valid_i;
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (sum_valid_i)
			ofm_o <= ofm_d;
	end

endmodule

// ==== src/fire_expand_top.sv ====
/*
 * Top of the APB-programmed fire4/fire5 expand 1x1 engine.
 * Register block, sequencer, MAC lanes and requantizer wired together.
 */
`timescale 1ns/100ps

module fire_expand_top
	import fire_pkg::*;
	import apb_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_gen,
	input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
	input  logic                      psel_i,
	input  logic                      penable_i,
	input  logic                      pwrite_i,
	input  logic [APB_DATA_WIDTH-1:0] pwdata_i,
	output logic [APB_DATA_WIDTH-1:0] prdata_o,
	output logic                      pready_o,
	output logic                      pslverr_o
);

	// Register block to datapath
	layer_e                           layer;
	logic                             pix_valid;
	logic [FIRE_WIDTH-1:0]            pix_data;
	logic                             clear;
	// Sequencer
	logic [FIRE_CHAN_BITS-1:0]        chan;
	logic                             last;
	logic [FIRE_PIX_CNT_WIDTH-1:0]    pix_count;
	// Lane sums and results
	logic signed [FIRE_ACC_WIDTH-1:0] sum [FIRE_CHOUT];
	logic                             sum_valid;
	logic [FIRE_WIDTH-1:0]            ofm [FIRE_CHOUT];
	logic                             ofm_valid;

	fire_apb_regs u_regs (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.pwdata_i    (pwdata_i),
		.pix_count_i (pix_count),
		.ofm_i       (ofm),
		.ofm_valid_i (ofm_valid),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.layer_o     (layer),
		.pix_valid_o (pix_valid),
		.pix_data_o  (pix_data),
		.clear_o     (clear)
	);

	// Sequencer and MAC lanes see the same beat
	fire_pixel_seq u_seq (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.clear_i     (clear),
		.pix_valid_i (pix_valid),
		.chan_o      (chan),
		.last_o      (last),
		.pix_count_o (pix_count)
	);

	fire_mac_array u_mac (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.clear_i     (clear),
		.layer_i     (layer),
		.pix_valid_i (pix_valid),
		.pix_data_i  (pix_data),
		.chan_i      (chan),
		.last_i      (last),
		.sum_o       (sum),
		.sum_valid_o (sum_valid)
	);

	fire_requant u_requant (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.layer_i     (layer),
		.sum_i       (sum),
		.sum_valid_i (sum_valid),
		.ofm_o       (ofm),
		.ofm_valid_o (ofm_valid)
	);

endmodule

// ==== dv/fire_expand_tb.sv ====
/*
 * Testbench for the fire expand engine. Drives pixels over APB, checks the
 * four results against a reference model, plus count, layer and slave errors.
 */
`timescale 1ns/100ps

module fire_expand_tb
	import fire_pkg::*;
	import apb_pkg::*;
();

	localparam int CLK_PERIOD    = 4;
	localparam int NUM_TESTS     = 5;
	localparam int PIX_PER_TEST  = 20;
	// Budget per pixel in APB transfers of 3 clocks each
	localparam int XFERS_PER_PIX = 20;
	localparam int CLKS_PER_XFER = 3;
	localparam int WATCHDOG_NS   = NUM_TESTS * PIX_PER_TEST * XFERS_PER_PIX *
		CLKS_PER_XFER * CLK_PERIOD;
	localparam int POLL_LIMIT    = 16;

	typedef logic [FIRE_CHIN-1:0][FIRE_WIDTH-1:0]  pix_vec_t;
	typedef logic [FIRE_CHOUT-1:0][FIRE_WIDTH-1:0] ofm_vec_t;

	logic                      clk = 1'b0;
	logic                      rst_gen;
	logic [APB_ADDR_WIDTH-1:0] paddr;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [APB_DATA_WIDTH-1:0] pwdata;
	logic [APB_DATA_WIDTH-1:0] prdata;
	logic                      pready;
	logic                      pslverr;

	// Expected results waiting for the compare process
	ofm_vec_t    exp_q [$];
	logic [15:0] lfsr_state = 16'd86;
	int          errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	fire_expand_top dut (
		.clk       (clk),
		.rst_gen   (rst_gen),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Random source and reference model
	////////////////////////////////////////////////////////////////////////////
	// Taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Channel values within +/-1.0 in Q2.14
	function automatic pix_vec_t rand_pixel();
		pix_vec_t    p;
		logic [15:0] r;
		for (int ch = 0; ch < FIRE_CHIN; ch++) begin
			r = rand_bits(15);
			p[ch] = {r[14], r[14:0]};
		end
		return p;
	endfunction

	// Wrapped dot product, bias, ReLU, bits 28:14
	function automatic ofm_vec_t ref_expand(layer_e layer, pix_vec_t pix);
		ofm_vec_t           res;
		logic signed [31:0] acc;
		logic signed [31:0] px;
		logic signed [31:0] wt;
		for (int l = 0; l < FIRE_CHOUT; l++) begin
			acc = '0;
			for (int ch = 0; ch < FIRE_CHIN; ch++) begin
				px  = 32'($signed(pix[ch]));
				wt  = 32'(FIRE_WEIGHTS[layer][l][ch]);
				acc = acc + px * wt;
			end
			acc = acc + FIRE_BIAS[layer][l];
			res[l] = acc[31] ? 16'h0000 : {1'b0, acc[28:14]};
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic check_ofm(string name, logic [FIRE_WIDTH-1:0] got,
		logic [FIRE_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(string name, logic [FIRE_PIX_CNT_WIDTH-1:0] got,
		logic [FIRE_PIX_CNT_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_layer(string name, layer_e got, layer_e exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %s expected %s", $time, name,
				got.name(), exp.name());
			errors++;
		end
	endtask

	// Single status bits such as done, pready and pslverr
	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB master
	////////////////////////////////////////////////////////////////////////////
	task automatic apb_write(logic [APB_ADDR_WIDTH-1:0] addr,
		logic [APB_DATA_WIDTH-1:0] data, output logic err);
		@(posedge clk);
		#1;
		paddr  = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel   = 1'b1;
		@(posedge clk);
		#1 penable = 1'b1;
		// Sample mid access phase once outputs settle
		@(negedge clk);
		err = pslverr;
		check_flag("pready", pready, 1'b1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(logic [APB_ADDR_WIDTH-1:0] addr,
		output logic [APB_DATA_WIDTH-1:0] data, output logic err);
		@(posedge clk);
		#1;
		paddr  = addr;
		pwrite = 1'b0;
		psel   = 1'b1;
		@(posedge clk);
		#1 penable = 1'b1;
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		check_flag("pready", pready, 1'b1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_outs(output ofm_vec_t got);
		logic [APB_DATA_WIDTH-1:0] rd;
		logic                      err;
		for (int l = 0; l < FIRE_CHOUT; l++) begin
			apb_read(REG_OUT0 + 8'(4 * l), rd, err);
			got[l] = rd[FIRE_WIDTH-1:0];
		end
	endtask

	task automatic read_count(output logic [FIRE_PIX_CNT_WIDTH-1:0] cnt);
		logic [APB_DATA_WIDTH-1:0] rd;
		logic                      err;
		apb_read(REG_STATUS, rd, err);
		cnt = rd[STATUS_CNT_LSB +: FIRE_PIX_CNT_WIDTH];
	endtask

	// Poll REG_STATUS until done or the poll limit
	task automatic wait_done();
		logic [APB_DATA_WIDTH-1:0] rd;
		logic                      err;
		int                        polls;
		polls = 0;
		rd    = '0;
		while (!rd[STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
			apb_read(REG_STATUS, rd, err);
			polls++;
		end
		if (!rd[STATUS_DONE_BIT]) begin
			$display("Done flag never rose after the last channel write (%0t ns)", $time);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////
	// Also clears count and channel index
	task automatic set_layer(layer_e layer);
		logic [APB_DATA_WIDTH-1:0] rd;
		logic                      err;
		apb_write(REG_CTRL, 32'(layer), err);
		check_flag("pslverr on ctrl write", err, 1'b0);
		apb_read(REG_CTRL, rd, err);
		check_layer("layer", layer_e'(rd[0]), layer);
	endtask

	// Eight channels then hand the expectation over and wait for the check
	task automatic send_checked(layer_e layer, pix_vec_t pix);
		logic err;
		for (int ch = 0; ch < FIRE_CHIN; ch++) begin
			apb_write(REG_PIX, 32'(pix[ch]), err);
			check_flag("pslverr on pixel write", err, 1'b0);
		end
		exp_q.push_back(ref_expand(layer, pix));
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic end_test(string name, int errs_at_start);
		if (errors == errs_at_start) begin
			tests_passed++;
			$display("Test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAIL", name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////
	task automatic test_reset();
		logic [APB_DATA_WIDTH-1:0] rd;
		logic                      err;
		ofm_vec_t                  got;
		apb_read(REG_STATUS, rd, err);
		check_count("pix_count", rd[STATUS_CNT_LSB +: FIRE_PIX_CNT_WIDTH], '0);
		check_flag("done", rd[STATUS_DONE_BIT], 1'b0);
		apb_read(REG_CTRL, rd, err);
		check_layer("layer", layer_e'(rd[0]), LAYER_FIRE4);
		read_outs(got);
		for (int l = 0; l < FIRE_CHOUT; l++)
			check_ofm($sformatf("ofm[%0d]", l), got[l], '0);
	endtask

	// Fire5 run opens with two pixels that drive lanes 0 and 2 negative
	task automatic test_pixels(layer_e layer);
		logic [FIRE_PIX_CNT_WIDTH-1:0] cnt;
		pix_vec_t                      pix;
		ofm_vec_t                      exp_v;
		int                            zeros;
		zeros = 0;
		set_layer(layer);
		for (int n = 0; n < PIX_PER_TEST; n++) begin
			if (layer == LAYER_FIRE5 && n == 0)
				pix = {FIRE_CHIN{16'h2000}};
			else if (layer == LAYER_FIRE5 && n == 1)
				pix = pix_vec_t'(16'h4000);
			else
				pix = rand_pixel();
			exp_v = ref_expand(layer, pix);
			for (int l = 0; l < FIRE_CHOUT; l++)
				zeros += (exp_v[l] == '0) ? 1 : 0;
			send_checked(layer, pix);
		end
		read_count(cnt);
		check_count("pix_count", cnt, FIRE_PIX_CNT_WIDTH'(PIX_PER_TEST));
		if (layer == LAYER_FIRE5 && zeros == 0) begin
			$display("No lane was clamped to zero by the ReLU in the fire5 run");
			errors++;
		end
	endtask

	task automatic test_count();
		logic [FIRE_PIX_CNT_WIDTH-1:0] cnt;
		pix_vec_t                      half;
		logic                          err;
		set_layer(LAYER_FIRE4);
		read_count(cnt);
		check_count("pix_count", cnt, '0);
		for (int n = 0; n < 3; n++)
			send_checked(LAYER_FIRE4, rand_pixel());
		read_count(cnt);
		check_count("pix_count", cnt, 16'd3);
		// Five channels that a control write then drops
		half = rand_pixel();
		for (int ch = 0; ch < 5; ch++)
			apb_write(REG_PIX, 32'(half[ch]), err);
		set_layer(LAYER_FIRE4);
		read_count(cnt);
		check_count("pix_count", cnt, '0);
		send_checked(LAYER_FIRE4, rand_pixel());
		read_count(cnt);
		check_count("pix_count", cnt, 16'd1);
	endtask

	task automatic test_slverr();
		logic [APB_DATA_WIDTH-1:0] rd;
		logic                      err;
		pix_vec_t                  pix;
		ofm_vec_t                  exp_v;
		ofm_vec_t                  after;
		// One known pixel in place before the bad accesses
		set_layer(LAYER_FIRE4);
		pix   = rand_pixel();
		exp_v = ref_expand(LAYER_FIRE4, pix);
		send_checked(LAYER_FIRE4, pix);
		apb_read(REG_STATUS, rd, err);
		check_flag("pslverr on status read", err, 1'b0);
		apb_write(8'h40, 32'hFFFF_FFFF, err);
		check_flag("pslverr on unmapped write", err, 1'b1);
		apb_read(8'h0C, rd, err);
		check_flag("pslverr on unmapped read", err, 1'b1);
		apb_write(REG_STATUS, 32'hFFFF_0000, err);
		check_flag("pslverr on status write", err, 1'b1);
		apb_read(REG_STATUS, rd, err);
		check_count("pix_count", rd[STATUS_CNT_LSB +: FIRE_PIX_CNT_WIDTH], 16'd1);
		check_flag("done", rd[STATUS_DONE_BIT], 1'b1);
		read_outs(after);
		for (int l = 0; l < FIRE_CHOUT; l++)
			check_ofm($sformatf("ofm[%0d]", l), after[l], exp_v[l]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Processes
	////////////////////////////////////////////////////////////////////////////
	// Compare process takes the bus while the stimulus waits
	initial begin : compare_proc
		ofm_vec_t got;
		ofm_vec_t exp_v;
		forever begin
			while (exp_q.size() == 0)
				@(posedge clk);
			exp_v = exp_q[0];
			wait_done();
			read_outs(got);
			for (int l = 0; l < FIRE_CHOUT; l++)
				check_ofm($sformatf("ofm[%0d]", l), got[l], exp_v[l]);
			exp_q.delete(0);
		end
	end

	initial begin : watchdog_proc
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin : main_proc
		int e0;
		rst_gen = 1'b1;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		repeat (2) @(posedge clk);
		#1 rst_gen = 1'b0;

		e0 = errors;
		test_reset();
		end_test("reset", e0);
		e0 = errors;
		test_pixels(LAYER_FIRE4);
		end_test("fire4 pixels", e0);
		e0 = errors;
		test_pixels(LAYER_FIRE5);
		end_test("fire5 pixels", e0);
		e0 = errors;
		test_count();
		end_test("pixel count", e0);
		e0 = errors;
		test_slverr();
		end_test("slave errors", e0);

		$display("Tests passed: %0d, failed: %0d, check errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== fire_expand.f ====
src/fire_pkg.sv
src/apb_pkg.sv
src/fire_apb_regs.sv
src/fire_pixel_seq.sv
src/fire_mac_array.sv
src/fire_requant.sv
src/fire_expand_top.sv
dv/fire_expand_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fire expand testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation failed"

verilator --binary --timing -f fire_expand.f --top-module fire_expand_tb \
	-Mdir obj_dir -o fire_expand_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fire_expand_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
	exit 1
fi
exit 0
